/* logic/axil_mem_config.svh */
`ifndef AXIL_MEM_CONFIG_SVH
`define AXIL_MEM_CONFIG_SVH

// Byte address width of the AXI4-Lite slave and the command bus
`define AXIL_ADDR_WIDTH 32

// Data width, fixed so the legal sizes are 1, 2 and 4 bytes
`define AXIL_DATA_WIDTH 32

// Scratch memory depth in words
`define MEM_WORDS 16

`endif

/* logic/axil_mem_pkg.sv */
`include "axil_mem_config.svh"

package axil_mem_pkg;

  // Message types on the command/response bus
  typedef enum logic [1:0]
  {
    e_mem_uc_rd = 2'b00,
    e_mem_uc_wr = 2'b01,
    e_mem_rd    = 2'b10,
    e_mem_wr    = 2'b11
  } mem_msg_e;

  typedef enum logic [1:0]
  {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10
  } mem_size_e;

  // Encodings as on the AXI bus
  typedef enum logic [1:0]
  {
    e_resp_okay   = 2'b00,
    e_resp_slverr = 2'b10
  } axi_resp_e;

  typedef enum logic [1:0]
  {
    e_ready      = 2'b00,
    e_send_read  = 2'b01,
    e_send_write = 2'b10
  } client_state_e;

  typedef struct packed
  {
    mem_msg_e                    msg_type;
    mem_size_e                   size;
    logic [`AXIL_ADDR_WIDTH-1:0] addr;
  } mem_cmd_header_s;

  // Err set for an address outside the endpoint
  typedef struct packed
  {
    mem_msg_e msg_type;
    logic     err;
  } mem_resp_header_s;

endpackage

/* logic/axil_mem_client.sv */
`include "axil_mem_config.svh"

module axil_mem_client
  import axil_mem_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  logic [`AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr_i,
  input  logic [2:0]                    s_axil_awprot_i,
  input  logic                          s_axil_awvalid_i,
  output logic                          s_axil_awready_o,

  input  logic [`AXIL_DATA_WIDTH-1:0]   s_axil_wdata_i,
  input  logic [`AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb_i,
  input  logic                          s_axil_wvalid_i,
  output logic                          s_axil_wready_o,

  output axi_resp_e                     s_axil_bresp_o,
  output logic                          s_axil_bvalid_o,
  input  logic                          s_axil_bready_i,

  input  logic [`AXIL_ADDR_WIDTH-1:0]   s_axil_araddr_i,
  input  logic [2:0]                    s_axil_arprot_i,
  input  logic                          s_axil_arvalid_i,
  output logic                          s_axil_arready_o,

  output logic [`AXIL_DATA_WIDTH-1:0]   s_axil_rdata_o,
  output axi_resp_e                     s_axil_rresp_o,
  output logic                          s_axil_rvalid_o,
  input  logic                          s_axil_rready_i,

  output mem_cmd_header_s               cmd_header_o,
  output logic [`AXIL_DATA_WIDTH-1:0]   cmd_data_o,
  output logic                          cmd_v_o,
  input  logic                          cmd_ready_i,

  input  mem_resp_header_s              resp_header_i,
  input  logic [`AXIL_DATA_WIDTH-1:0]   resp_data_i,
  input  logic                          resp_v_i,
  output logic                          resp_yumi_o
);

  localparam int STRB_W = `AXIL_DATA_WIDTH / 8;

  client_state_e               state_r;
  client_state_e               state_n;
  logic [`AXIL_ADDR_WIDTH-1:0] awaddr_r;
  mem_size_e                   wr_size;
  logic                        strb_legal;
  logic                        aw_fire;

  assign aw_fire = s_axil_awvalid_i & s_axil_awready_o;

  // Access size from the write strobe
  always_comb
  begin
    strb_legal = 1'b1;
    case (s_axil_wstrb_i)
      STRB_W'('h1): wr_size = e_size_1;
      STRB_W'('h3): wr_size = e_size_2;
      STRB_W'('hF): wr_size = e_size_4;
      default:
      begin
        wr_size    = e_size_4;
        strb_legal = 1'b0;
      end
    endcase
  end

  // Address held for an address-first write
  always_ff @(posedge clk_i)
  begin
    if (aw_fire)
    begin
      awaddr_r <= s_axil_awaddr_i;
    end
  end

  always_comb
  begin
    state_n               = state_r;
    cmd_header_o.msg_type = e_mem_uc_wr;
    cmd_header_o.size     = wr_size;
    cmd_header_o.addr     = s_axil_awaddr_i;
    cmd_data_o            = s_axil_wdata_i;
    cmd_v_o               = 1'b0;
    s_axil_awready_o      = 1'b0;
    s_axil_wready_o       = 1'b0;
    s_axil_arready_o      = 1'b0;

    case (state_r)
      // Writes win here; AW alone is buffered, a read waits one cycle
      e_ready:
      begin
        s_axil_awready_o = cmd_ready_i;
        s_axil_wready_o  = cmd_ready_i;
        cmd_v_o          = s_axil_awvalid_i & s_axil_wvalid_i;
        if (s_axil_awvalid_i && cmd_ready_i && !s_axil_wvalid_i)
        begin
          state_n = e_send_write;
        end
        else if (s_axil_arvalid_i)
        begin
          state_n = e_send_read;
        end
      end
      e_send_read:
      begin
        s_axil_arready_o      = cmd_ready_i;
        cmd_header_o.msg_type = e_mem_uc_rd;
        cmd_header_o.size     = e_size_4;
        cmd_header_o.addr     = s_axil_araddr_i;
        cmd_v_o               = s_axil_arvalid_i;
        if (s_axil_arvalid_i && cmd_ready_i)
        begin
          state_n = e_ready;
        end
      end
      // Data is taken from the live W bus, W itself handshakes later in e_ready
      e_send_write:
      begin
        cmd_header_o.addr = awaddr_r;
        cmd_v_o           = s_axil_wvalid_i;
        if (s_axil_wvalid_i && cmd_ready_i)
        begin
          state_n = e_ready;
        end
      end
      default: state_n = e_ready;
    endcase
  end

  // Route the response by message type
  always_comb
  begin
    s_axil_rdata_o  = resp_data_i;
    s_axil_rresp_o  = resp_header_i.err ? e_resp_slverr : e_resp_okay;
    s_axil_rvalid_o = resp_v_i & (resp_header_i.msg_type inside {e_mem_uc_rd, e_mem_rd});
    s_axil_bresp_o  = resp_header_i.err ? e_resp_slverr : e_resp_okay;
    s_axil_bvalid_o = resp_v_i & (resp_header_i.msg_type inside {e_mem_uc_wr, e_mem_wr});
    resp_yumi_o     = (s_axil_rvalid_o & s_axil_rready_i)
                    | (s_axil_bvalid_o & s_axil_bready_i);
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_ready;
    end
    else
    begin
      state_r <= state_n;
    end
  end

  a_wstrb_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    s_axil_wvalid_i |-> strb_legal);

  // Protection modes are not supported
  a_awprot_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    s_axil_awvalid_i |-> (s_axil_awprot_i == 3'b000));
  a_arprot_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    s_axil_arvalid_i |-> (s_axil_arprot_i == 3'b000));

endmodule

/* logic/mem_scratch_endpoint.sv */
`include "axil_mem_config.svh"

module mem_scratch_endpoint
  import axil_mem_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_i,

  input  mem_cmd_header_s             cmd_header_i,
  input  logic [`AXIL_DATA_WIDTH-1:0] cmd_data_i,
  input  logic                        cmd_v_i,
  output logic                        cmd_ready_o,

  output mem_resp_header_s            resp_header_o,
  output logic [`AXIL_DATA_WIDTH-1:0] resp_data_o,
  output logic                        resp_v_o,
  input  logic                        resp_yumi_i
);

  localparam int IDX_W = $clog2(`MEM_WORDS);
  localparam int BYTES = `AXIL_DATA_WIDTH / 8;

  logic [`AXIL_DATA_WIDTH-1:0] mem_r [`MEM_WORDS];

  // Command stage, filled on acceptance and executed on the next edge
  logic                        pend_r;
  mem_cmd_header_s             hdr_r;
  logic [`AXIL_DATA_WIDTH-1:0] data_r;

  logic                        resp_v_r;
  mem_resp_header_s            resp_hdr_r;
  logic [`AXIL_DATA_WIDTH-1:0] resp_data_r;

  logic                        cmd_fire;
  logic                        is_write;
  logic                        in_range;
  logic [IDX_W-1:0]            word_idx;
  logic [1:0]                  byte_off;
  logic [BYTES-1:0]            size_mask;
  logic [BYTES-1:0]            byte_en;
  logic [`AXIL_DATA_WIDTH-1:0] wdata_shift;

  // One command in flight; a held response blocks the next
  assign cmd_ready_o = ~pend_r & ~resp_v_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  assign is_write = hdr_r.msg_type inside {e_mem_uc_wr, e_mem_wr};
  assign in_range = (hdr_r.addr >> 2) < `AXIL_ADDR_WIDTH'(`MEM_WORDS);
  assign word_idx = hdr_r.addr[IDX_W+1:2];
  assign byte_off = hdr_r.addr[1:0];

  always_comb
  begin
    case (hdr_r.size)
      e_size_1: size_mask = BYTES'('b0001);
      e_size_2: size_mask = BYTES'('b0011);
      default:  size_mask = '1;
    endcase
  end

  // Low bytes of the data moved up to the addressed lane
  assign byte_en     = size_mask << byte_off;
  assign wdata_shift = data_r << {byte_off, 3'b000};

  always_ff @(posedge clk_i)
  begin
    if (pend_r && is_write && in_range)
    begin
      for (int b = 0; b < BYTES; b++)
      begin
        if (byte_en[b])
        begin
          mem_r[word_idx][8*b +: 8] <= wdata_shift[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      hdr_r  <= cmd_header_i;
      data_r <= cmd_data_i;
    end
    if (pend_r)
    begin
      resp_hdr_r.msg_type <= hdr_r.msg_type;
      resp_hdr_r.err      <= ~in_range;
      resp_data_r         <= (is_write || !in_range) ? '0 : mem_r[word_idx];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pend_r   <= 1'b0;
      resp_v_r <= 1'b0;
    end
    else
    begin
      pend_r <= cmd_fire;
      if (pend_r)
      begin
        resp_v_r <= 1'b1;
      end
      else if (resp_yumi_i)
      begin
        resp_v_r <= 1'b0;
      end
    end
  end

  assign resp_header_o = resp_hdr_r;
  assign resp_data_o   = resp_data_r;
  assign resp_v_o      = resp_v_r;

  a_cmd_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_fire |-> !((cmd_header_i.size == e_size_2 && cmd_header_i.addr[0])
                || (cmd_header_i.size == e_size_4 && cmd_header_i.addr[1:0] != 2'b00)));

  // Client must only consume a valid response
  a_yumi_with_v: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_yumi_i |-> resp_v_o);

endmodule

/* logic/axil_mem_bridge.sv */
`include "axil_mem_config.svh"

module axil_mem_bridge
  import axil_mem_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  logic [`AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr_i,
  input  logic [2:0]                    s_axil_awprot_i,
  input  logic                          s_axil_awvalid_i,
  output logic                          s_axil_awready_o,

  input  logic [`AXIL_DATA_WIDTH-1:0]   s_axil_wdata_i,
  input  logic [`AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb_i,
  input  logic                          s_axil_wvalid_i,
  output logic                          s_axil_wready_o,

  output axi_resp_e                     s_axil_bresp_o,
  output logic                          s_axil_bvalid_o,
  input  logic                          s_axil_bready_i,

  input  logic [`AXIL_ADDR_WIDTH-1:0]   s_axil_araddr_i,
  input  logic [2:0]                    s_axil_arprot_i,
  input  logic                          s_axil_arvalid_i,
  output logic                          s_axil_arready_o,

  output logic [`AXIL_DATA_WIDTH-1:0]   s_axil_rdata_o,
  output axi_resp_e                     s_axil_rresp_o,
  output logic                          s_axil_rvalid_o,
  input  logic                          s_axil_rready_i
);

  // Command/response bus between client and scratch memory
  mem_cmd_header_s             cmd_header;
  logic [`AXIL_DATA_WIDTH-1:0] cmd_data;
  logic                        cmd_v;
  logic                        cmd_ready;
  mem_resp_header_s            resp_header;
  logic [`AXIL_DATA_WIDTH-1:0] resp_data;
  logic                        resp_v;
  logic                        resp_yumi;

  axil_mem_client u_client
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awprot_i  (s_axil_awprot_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arprot_i  (s_axil_arprot_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .cmd_header_o     (cmd_header),
    .cmd_data_o       (cmd_data),
    .cmd_v_o          (cmd_v),
    .cmd_ready_i      (cmd_ready),
    .resp_header_i    (resp_header),
    .resp_data_i      (resp_data),
    .resp_v_i         (resp_v),
    .resp_yumi_o      (resp_yumi)
  );

  mem_scratch_endpoint u_endpoint
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cmd_header_i  (cmd_header),
    .cmd_data_i    (cmd_data),
    .cmd_v_i       (cmd_v),
    .cmd_ready_o   (cmd_ready),
    .resp_header_o (resp_header),
    .resp_data_o   (resp_data),
    .resp_v_o      (resp_v),
    .resp_yumi_i   (resp_yumi)
  );

endmodule

/* dv/axil_mem_bridge_tb.sv */
`include "axil_mem_config.svh"

module axil_mem_bridge_tb
  import axil_mem_pkg::*;
();

  // About 64 transactions of at most 20 cycles with a factor of 2.5
  localparam int TXN_COUNT  = 64;
  localparam int TXN_CYCLES = 20;
  localparam int TIMEOUT    = TXN_COUNT * TXN_CYCLES * 5 / 2;

  logic                          clk_i;
  logic                          reset_i;
  logic [`AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr_i;
  logic [2:0]                    s_axil_awprot_i;
  logic                          s_axil_awvalid_i;
  logic                          s_axil_awready_o;
  logic [`AXIL_DATA_WIDTH-1:0]   s_axil_wdata_i;
  logic [`AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb_i;
  logic                          s_axil_wvalid_i;
  logic                          s_axil_wready_o;
  axi_resp_e                     s_axil_bresp_o;
  logic                          s_axil_bvalid_o;
  logic                          s_axil_bready_i;
  logic [`AXIL_ADDR_WIDTH-1:0]   s_axil_araddr_i;
  logic [2:0]                    s_axil_arprot_i;
  logic                          s_axil_arvalid_i;
  logic                          s_axil_arready_o;
  logic [`AXIL_DATA_WIDTH-1:0]   s_axil_rdata_o;
  axi_resp_e                     s_axil_rresp_o;
  logic                          s_axil_rvalid_o;
  logic                          s_axil_rready_i;

  // Expected contents of the scratch memory
  logic [31:0] ref_mem [`MEM_WORDS];
  integer      seed   = 15;
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;

  axil_mem_bridge u_dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  function automatic axi_resp_e range_resp(input logic [31:0] addr);
    if (addr[31:2] < `MEM_WORDS)
      return e_resp_okay;
    else
      return e_resp_slverr;
  endfunction

  // Size from the strobe with the low data bytes placed from the byte address up
  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    int nbytes;
    int i;
    nbytes = (strb == 4'h1) ? 1 : (strb == 4'h3) ? 2 : 4;
    if (addr[31:2] < `MEM_WORDS)
    begin
      for (i = 0; i < nbytes; i++)
      begin
        ref_mem[addr[5:2]][8*(addr[1:0]+i) +: 8] = data[8*i +: 8];
      end
    end
  endtask

  task automatic wait_write_resp(input logic [31:0] addr, input int hold);
    logic [1:0] held_resp;
    int         i;
    if (hold > 0)
    begin
      do @(posedge clk_i); while (!s_axil_bvalid_o);
      held_resp = s_axil_bresp_o;
      // Read of the same word queued behind the held response
      s_axil_araddr_i  <= addr;
      s_axil_arvalid_i <= 1'b1;
      for (i = 0; i < hold; i++)
      begin
        @(posedge clk_i);
        if (!s_axil_bvalid_o)
        begin
          errors++;
          $display("BVALID dropped while BREADY was held low");
        end
        check_value("s_axil_bresp_o", s_axil_bresp_o, held_resp);
        if (s_axil_awready_o || s_axil_arready_o)
        begin
          errors++;
          $display("Address channel ready while a write response was held");
        end
      end
      s_axil_bready_i <= 1'b1;
    end
    do @(posedge clk_i); while (!(s_axil_bvalid_o && s_axil_bready_i));
    check_value("s_axil_bresp_o", s_axil_bresp_o, range_resp(addr));
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int hold);
    s_axil_awaddr_i  <= addr;
    s_axil_wdata_i   <= data;
    s_axil_wstrb_i   <= strb;
    s_axil_awvalid_i <= 1'b1;
    s_axil_wvalid_i  <= 1'b1;
    s_axil_bready_i  <= (hold == 0);
    do @(posedge clk_i); while (!(s_axil_awready_o && s_axil_wready_o));
    s_axil_awvalid_i <= 1'b0;
    s_axil_wvalid_i  <= 1'b0;
    model_write(addr, data, strb);
    wait_write_resp(addr, hold);
  endtask

  // W is raised only after AW has transferred and held until it transfers too
  task automatic axil_write_addr_first(input logic [31:0] addr, input logic [31:0] data,
                                       input logic [3:0] strb);
    s_axil_awaddr_i  <= addr;
    s_axil_awvalid_i <= 1'b1;
    s_axil_bready_i  <= 1'b1;
    do @(posedge clk_i); while (!s_axil_awready_o);
    s_axil_awvalid_i <= 1'b0;
    s_axil_wdata_i   <= data;
    s_axil_wstrb_i   <= strb;
    s_axil_wvalid_i  <= 1'b1;
    model_write(addr, data, strb);
    // Buffered write goes out on this edge while W itself must wait
    @(posedge clk_i);
    check_value("s_axil_wready_o", s_axil_wready_o, 1'b0);
    wait_write_resp(addr, 0);
    do @(posedge clk_i); while (!s_axil_wready_o);
    s_axil_wvalid_i <= 1'b0;
  endtask

  task automatic axil_read_check(input logic [31:0] addr, input int hold);
    logic [31:0] exp_data;
    logic [31:0] held_data;
    int          i;
    exp_data = (addr[31:2] < `MEM_WORDS) ? ref_mem[addr[5:2]] : 32'h0;
    s_axil_araddr_i  <= addr;
    s_axil_arvalid_i <= 1'b1;
    s_axil_rready_i  <= (hold == 0);
    do @(posedge clk_i); while (!s_axil_arready_o);
    s_axil_arvalid_i <= 1'b0;
    if (hold > 0)
    begin
      do @(posedge clk_i); while (!s_axil_rvalid_o);
      held_data = s_axil_rdata_o;
      for (i = 0; i < hold; i++)
      begin
        @(posedge clk_i);
        if (!s_axil_rvalid_o)
        begin
          errors++;
          $display("RVALID dropped while RREADY was held low");
        end
        check_value("s_axil_rdata_o", s_axil_rdata_o, held_data);
        if (s_axil_awready_o || s_axil_arready_o)
        begin
          errors++;
          $display("Address channel ready while a read response was held");
        end
      end
      s_axil_rready_i <= 1'b1;
    end
    do @(posedge clk_i); while (!(s_axil_rvalid_o && s_axil_rready_i));
    check_value("s_axil_rdata_o", s_axil_rdata_o, exp_data);
    check_value("s_axil_rresp_o", s_axil_rresp_o, range_resp(addr));
  endtask

  task automatic check_reset_state();
    check_value("s_axil_bvalid_o", s_axil_bvalid_o, 1'b0);
    check_value("s_axil_rvalid_o", s_axil_rvalid_o, 1'b0);
    axil_write(32'h14, $random(seed), 4'hF, 0);
    axil_read_check(32'h14, 0);
  endtask

  task automatic fill_full_words();
    int w;
    for (w = 0; w < `MEM_WORDS; w++)
      axil_write(w * 4, $random(seed), 4'hF, 0);
    for (w = 0; w < `MEM_WORDS; w++)
      axil_read_check(w * 4, 0);
  endtask

  // Bytes into word 3 and halfwords into word 7
  task automatic write_sub_words();
    int off;
    for (off = 0; off < 4; off++)
    begin
      axil_write(32'h0C + off, $random(seed), 4'h1, 0);
      axil_read_check(32'h0C, 0);
    end
    for (off = 0; off < 4; off += 2)
    begin
      axil_write(32'h1C + off, $random(seed), 4'h3, 0);
      axil_read_check(32'h1C, 0);
    end
  endtask

  task automatic write_addr_first();
    axil_write_addr_first(32'h24, $random(seed), 4'hF);
    axil_read_check(32'h24, 0);
    axil_write_addr_first(32'h2A, $random(seed), 4'h3);
    axil_read_check(32'h28, 0);
  endtask

  // 0x40 aliases word 0 in the low index bits
  task automatic access_out_of_range();
    axil_write(32'h40, $random(seed), 4'hF, 0);
    axil_read_check(32'h7C, 0);
    axil_read_check(32'h100, 0);
    axil_read_check(32'h00, 0);
  endtask

  task automatic stall_responses();
    axil_write(32'h30, $random(seed), 4'hF, 6);
    axil_read_check(32'h30, 6);
    axil_write(32'h34, $random(seed), 4'hF, 0);
    axil_read_check(32'h34, 0);
  endtask

  initial
  begin
    reset_i          <= 1'b1;
    s_axil_awaddr_i  <= '0;
    s_axil_awprot_i  <= 3'b000;
    s_axil_awvalid_i <= 1'b0;
    s_axil_wdata_i   <= '0;
    s_axil_wstrb_i   <= 4'hF;
    s_axil_wvalid_i  <= 1'b0;
    s_axil_bready_i  <= 1'b1;
    s_axil_araddr_i  <= '0;
    s_axil_arprot_i  <= 3'b000;
    s_axil_arvalid_i <= 1'b0;
    s_axil_rready_i  <= 1'b1;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_reset_state();
    fill_full_words();
    write_sub_words();
    write_addr_first();
    access_out_of_range();
    stall_responses();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* axil_mem_bridge.f */
+incdir+logic
logic/axil_mem_pkg.sv
logic/axil_mem_client.sv
logic/mem_scratch_endpoint.sv
logic/axil_mem_bridge.sv
dv/axil_mem_bridge_tb.sv
